// ==== serial_bus_top.f ====
hdl/sbus_wb_pkg.sv
hdl/sbus_link_pkg.sv
hdl/sbus_master_ctrl.sv
hdl/sbus_link_shifter.sv
hdl/sbus_slave_mem.sv
hdl/serial_bus_top.sv
testbench/serial_bus_tb.sv

// ==== Bender.yml ====
package:
  name: serial_bus

sources:
  # packages first, link package uses the host package
  - hdl/sbus_wb_pkg.sv
  - hdl/sbus_link_pkg.sv
  - hdl/sbus_master_ctrl.sv
  - hdl/sbus_link_shifter.sv
  - hdl/sbus_slave_mem.sv
  - hdl/serial_bus_top.sv
  - target: test
    files:
      - testbench/serial_bus_tb.sv

// ==== testbench/serial_bus_tests.txt ====
# columns: test name, op W or R, host word address in hex, data in hex, expected err
# data is the write word, or the expected read word for R; addr bits 9:8 select the slave
wr_s1        W 110 a5a50001 0
rd_s1        R 110 a5a50001 0
wr_s2        W 220 5a5a0002 0
rd_s2        R 220 5a5a0002 0
wr_s3        W 3ff 12345678 0
rd_s3        R 3ff 12345678 0
wr_s1_x40    W 140 11111111 0
wr_s3_x40    W 340 33333333 0
wr_s2_x40    W 240 22222222 0
rd_s1_x40    R 140 11111111 0
rd_s3_x40    R 340 33333333 0
rd_s2_x40    R 240 22222222 0
wr_id0       W 040 deadbeef 1
rd_id0       R 040 00000000 1
rd_after_id0 R 140 11111111 0
b2b_wr_a     W 105 cafef00d 0
b2b_wr_b     W 305 0badc0de 0
b2b_rd_a     R 105 cafef00d 0
b2b_wr_a2    W 105 fedcba98 0
b2b_rd_a2    R 105 fedcba98 0
b2b_rd_b     R 305 0badc0de 0
b2b_id0      R 0ff 00000000 1
b2b_rd_s2    R 220 5a5a0002 0
rg_wr        W 2aa 80000001 0
rg_wr2       W 2aa 7ffffffe 0
rg_rd        R 2aa 7ffffffe 0
rg_wr0       W 300 00000000 0
rg_rd0       R 300 00000000 0
rg_rd_s1     R 110 a5a50001 0
rg_rd_s3     R 3ff 12345678 0

// ==== testbench/serial_bus_tb.sv ====
// Testbench for the serial memory bus.
// Reads access vectors from a text file, runs Wishbone classic cycles
// against the top level and checks ack, err and read data.
`timescale 1ns/1ps

module serial_bus_tb;

    localparam int WAIT_LIMIT = 300;
    localparam string TEST_FILE = "testbench/serial_bus_tests.txt";

    logic                 clk;
    logic                 rstN;
    sbus_wb_pkg::wb_req_t wb_req;
    sbus_wb_pkg::wb_rsp_t wb_rsp;

    int          data_errs;
    int          flag_errs;
    int          other_errs;
    logic [31:0] seed;

    serial_bus_top dut_i (
        .clk    (clk),
        .rstN   (rstN),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    // 4 ns period
    always begin
        #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_data(input string name, input sbus_wb_pkg::wb_data_t exp,
                              input sbus_wb_pkg::wb_data_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            flag_errs++;
        end
    endtask

    task automatic drive_access(input logic we,
                                input logic [sbus_wb_pkg::HOST_ADR_W-1:0] adr,
                                input sbus_wb_pkg::wb_data_t dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
    endtask

    task automatic drive_idle();
        wb_req = '0;
    endtask

    // returns just after the edge that raised ack or err
    task automatic wait_response(output bit timed_out);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (wb_rsp.ack || wb_rsp.err) begin
                seen = 1'b1;
            end
        end
        timed_out = !seen;
    endtask

    initial begin
        int                    fd;
        int                    n;
        int                    exp_err;
        int                    gap;
        int                    test_cnt;
        string                 name;
        string                 op;
        logic [31:0]           adr_val;
        sbus_wb_pkg::wb_data_t dat_val;
        logic [8*128-1:0]      line;
        bit                    timed_out;
        bit                    abort;
        bit                    is_b2b;

        clk = 1'b0;
        rstN = 1'b0;
        wb_req = '0;
        data_errs = 0;
        flag_errs = 0;
        other_errs = 0;
        test_cnt = 0;
        abort = 1'b0;
        seed = 32'h8394_b03a;

        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;

        // response must be quiet before the first cycle
        check_err("reset_ack", 1'b0, wb_rsp.ack);
        check_err("reset_err", 1'b0, wb_rsp.err);

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test vector file %s", TEST_FILE);
            other_errs++;
            abort = 1'b1;
        end

        while (!abort) begin
            if ($feof(fd)) begin
                abort = 1'b1;
            end else begin
                line = '0;
                n = $fgets(line, fd);
                // comment and blank lines do not give five fields
                if (n > 0 && $sscanf(line, "%s %s %h %h %d",
                                     name, op, adr_val, dat_val, exp_err) == 5) begin
                    if (op != "W" && op != "R") begin
                        $display("test %s has an unknown operation %s", name, op);
                        other_errs++;
                    end else begin
                        test_cnt++;
                        if (op == "W") begin
                            drive_access(1'b1, adr_val[sbus_wb_pkg::HOST_ADR_W-1:0], dat_val);
                        end else begin
                            drive_access(1'b0, adr_val[sbus_wb_pkg::HOST_ADR_W-1:0], '0);
                        end
                        wait_response(timed_out);
                        if (timed_out) begin
                            $display("test %s got neither ack nor err within %0d cycles",
                                     name, WAIT_LIMIT);
                            other_errs++;
                            abort = 1'b1;
                        end else begin
                            check_err(name, exp_err[0], wb_rsp.err);
                            check_err({name, "_ack"}, !exp_err[0], wb_rsp.ack);
                            if (op == "R" && exp_err == 0) begin
                                check_data(name, dat_val, wb_rsp.dat);
                            end
                            drive_idle();

                            // b2b tests start the next access right away
                            seed = lcg_next(seed);
                            is_b2b = name.len() >= 3 && name.substr(0, 2) == "b2b";
                            gap = is_b2b ? 0 : int'((seed >> 16) % 8);
                            repeat (gap) begin
                                @(posedge clk);
                                #1;
                            end
                        end
                    end
                end
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        if (test_cnt == 0) begin
            $display("no test vectors were run");
            other_errs++;
        end

        $display("tests %0d, data errors %0d, flag errors %0d, other errors %0d",
                 test_cnt, data_errs, flag_errs, other_errs);
        if (data_errs + flag_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/serial_bus_top.sv ====
// Serial memory bus top level.
// Wishbone classic slave port in front of the master controller and
// link shifter, with three serial memory slaves on the shared lines.
`timescale 1ns/1ps

module serial_bus_top (
    input  logic                  clk,
    input  logic                  rstN,
    input  sbus_wb_pkg::wb_req_t  wb_req,
    output sbus_wb_pkg::wb_rsp_t  wb_rsp
);

    sbus_link_pkg::sbus_hdr_u   load_hdr;
    sbus_wb_pkg::wb_data_t      load_data;
    sbus_wb_pkg::wb_data_t      rx_word;
    logic                       is_write;
    logic                       start;
    logic                       tx_done;
    logic                       rx_done;
    logic                       merged_rd;
    logic                       merged_rd_valid;
    sbus_link_pkg::sbus_drive_t drive;
    sbus_link_pkg::sbus_resp_t  slave_rsp [sbus_link_pkg::SLAVES];

    sbus_master_ctrl ctrl_i (
        .clk             (clk),
        .rstN            (rstN),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .load_hdr        (load_hdr),
        .load_data       (load_data),
        .is_write        (is_write),
        .start           (start),
        .tx_done         (tx_done),
        .rx_word         (rx_word),
        .rx_done         (rx_done),
        .slave_rsp       (slave_rsp),
        .merged_rd       (merged_rd),
        .merged_rd_valid (merged_rd_valid)
    );

    sbus_link_shifter shifter_i (
        .clk             (clk),
        .rstN            (rstN),
        .load_hdr        (load_hdr),
        .load_data       (load_data),
        .is_write        (is_write),
        .start           (start),
        .merged_rd       (merged_rd),
        .merged_rd_valid (merged_rd_valid),
        .drive           (drive),
        .tx_done         (tx_done),
        .rx_word         (rx_word),
        .rx_done         (rx_done)
    );

    // slave IDs start at 1
    for (genvar i = 0; i < sbus_link_pkg::SLAVES; i++) begin : g_slave
        sbus_slave_mem slave_i (
            .clk   (clk),
            .rstN  (rstN),
            .drive (drive),
            .my_id (sbus_link_pkg::SID_W'(i + 1)),
            .resp  (slave_rsp[i])
        );
    end

endmodule

// ==== hdl/sbus_slave_mem.sv ====
// Serial memory slave.
// Captures the frame header from the control line, checks the start
// pattern and its own ID, then stores a shifted-in write word or shifts
// a stored word back MSB first. Frames for other slaves are skipped.
`timescale 1ns/1ps

module sbus_slave_mem (
    input  logic                             clk,
    input  logic                             rstN,
    input  sbus_link_pkg::sbus_drive_t       drive,
    input  logic [sbus_link_pkg::SID_W-1:0]  my_id,
    output sbus_link_pkg::sbus_resp_t        resp
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,
        S_WR,
        S_WR_STORE,
        S_RD_LOAD,
        S_RD_SHIFT,
        S_SKIP
    } slave_state_t;

    slave_state_t state;

    sbus_link_pkg::sbus_hdr_u            hdr_q;
    sbus_link_pkg::sbus_hdr_u            hdr_next;
    logic                                hdr_ok;
    logic [sbus_link_pkg::BIT_CNT_W-1:0] cnt;
    logic                                ready_q;
    sbus_wb_pkg::wb_data_t               wbuf;
    sbus_wb_pkg::wb_data_t               rbuf;

    sbus_wb_pkg::wb_data_t mem [2**sbus_link_pkg::LOC_ADR_W];

    // header as it stands once this cycle's control bit is in
    assign hdr_next.flat = {hdr_q.flat[sbus_link_pkg::HDR_W-2:0], drive.control};
    assign hdr_ok = (hdr_next.f.start == sbus_link_pkg::START_PAT) &&
                    (hdr_next.f.sid == my_id);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= S_IDLE;
            hdr_q   <= '0;
            cnt     <= '0;
            ready_q <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    // first start bit is a one
                    if (drive.control) begin
                        hdr_q <= hdr_next;
                        cnt   <= sbus_link_pkg::BIT_CNT_W'(1);
                        state <= S_HDR;
                    end
                end
                S_HDR: begin
                    hdr_q <= hdr_next;
                    cnt   <= cnt + 1'b1;
                    if (cnt == sbus_link_pkg::BIT_CNT_W'(sbus_link_pkg::HDR_W - 1)) begin
                        cnt <= '0;
                        if (hdr_ok) begin
                            ready_q <= 1'b0;
                            state   <= hdr_next.f.wr ? S_WR : S_RD_LOAD;
                        end else begin
                            state <= S_SKIP;
                        end
                    end
                end
                S_WR: begin
                    if (drive.valid) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == sbus_link_pkg::BIT_CNT_W'(sbus_wb_pkg::DATA_W - 1)) begin
                            cnt   <= '0;
                            state <= S_WR_STORE;
                        end
                    end
                end
                S_WR_STORE: begin
                    ready_q <= 1'b1;
                    state   <= S_IDLE;
                end
                S_RD_LOAD: begin
                    cnt   <= '0;
                    state <= S_RD_SHIFT;
                end
                S_RD_SHIFT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == sbus_link_pkg::BIT_CNT_W'(sbus_wb_pkg::DATA_W - 1)) begin
                        cnt     <= '0;
                        ready_q <= 1'b1;
                        state   <= S_IDLE;
                    end
                end
                S_SKIP: begin
                    // wait out the other slave's data phase
                    if (drive.control) begin
                        cnt <= '0;
                    end else if (cnt == sbus_link_pkg::BIT_CNT_W'(sbus_wb_pkg::DATA_W)) begin
                        cnt   <= '0;
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // word memory and shift buffers
    always_ff @(posedge clk) begin
        if (state == S_WR && drive.valid) begin
            wbuf <= {wbuf[sbus_wb_pkg::DATA_W-2:0], drive.wd};
        end
        if (state == S_WR_STORE) begin
            mem[hdr_q.f.addr] <= wbuf;
        end
        if (state == S_RD_LOAD) begin
            rbuf <= mem[hdr_q.f.addr];
        end else if (state == S_RD_SHIFT) begin
            rbuf <= rbuf << 1;
        end
    end

    assign resp.rd_valid = (state == S_RD_SHIFT);
    assign resp.rd       = resp.rd_valid && rbuf[sbus_wb_pkg::DATA_W-1];
    assign resp.ready    = ready_q;

    a_rd_not_ready: assert property (
        @(posedge clk) disable iff (!rstN) resp.rd_valid |-> !resp.ready
    ) else $error("read bit sent while ready is high");

endmodule

// ==== hdl/sbus_link_shifter.sv ====
// Serial link shifter on the master side.
// Sends the frame header and an optional write word MSB first, and
// gathers a returned read word from the merged slave read line.
`timescale 1ns/1ps

module sbus_link_shifter (
    input  logic                      clk,
    input  logic                      rstN,
    input  sbus_link_pkg::sbus_hdr_u  load_hdr,
    input  sbus_wb_pkg::wb_data_t     load_data,
    input  logic                      is_write,
    input  logic                      start,
    input  logic                      merged_rd,
    input  logic                      merged_rd_valid,
    output sbus_link_pkg::sbus_drive_t drive,
    output logic                      tx_done,
    output sbus_wb_pkg::wb_data_t     rx_word,
    output logic                      rx_done
);

    logic [sbus_link_pkg::FRAME_W-1:0]   tx_sr;
    logic [sbus_link_pkg::BIT_CNT_W-1:0] tx_cnt;
    logic [sbus_link_pkg::BIT_CNT_W-1:0] tx_last;
    logic                                tx_busy;
    logic                                tx_wr;
    logic                                in_data;
    sbus_wb_pkg::wb_data_t               rx_sr;
    logic [sbus_link_pkg::BIT_CNT_W-1:0] rx_cnt;
    logic                                rx_done_q;

    // reads end after the header
    assign tx_last = tx_wr ? sbus_link_pkg::BIT_CNT_W'(sbus_link_pkg::FRAME_W - 1)
                           : sbus_link_pkg::BIT_CNT_W'(sbus_link_pkg::HDR_W - 1);
    assign in_data = tx_cnt >= sbus_link_pkg::BIT_CNT_W'(sbus_link_pkg::HDR_W);

    assign drive.control = tx_busy && !in_data && tx_sr[sbus_link_pkg::FRAME_W-1];
    assign drive.wd      = tx_busy && in_data && tx_sr[sbus_link_pkg::FRAME_W-1];
    assign drive.valid   = tx_busy && in_data;
    assign tx_done       = tx_busy && (tx_cnt == tx_last);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            tx_busy   <= 1'b0;
            tx_wr     <= 1'b0;
            tx_cnt    <= '0;
            rx_cnt    <= '0;
            rx_done_q <= 1'b0;
        end else begin
            if (start) begin
                tx_busy <= 1'b1;
                tx_wr   <= is_write;
                tx_cnt  <= '0;
            end else if (tx_done) begin
                tx_busy <= 1'b0;
            end else if (tx_busy) begin
                tx_cnt <= tx_cnt + 1'b1;
            end

            rx_done_q <= 1'b0;
            if (merged_rd_valid) begin
                if (rx_cnt == sbus_link_pkg::BIT_CNT_W'(sbus_wb_pkg::DATA_W - 1)) begin
                    rx_cnt    <= '0;
                    rx_done_q <= 1'b1;
                end else begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tx_sr <= {load_hdr.flat, load_data};
        end else if (tx_busy) begin
            tx_sr <= tx_sr << 1;
        end
        if (merged_rd_valid) begin
            rx_sr <= {rx_sr[sbus_wb_pkg::DATA_W-2:0], merged_rd};
        end
    end

    assign rx_word = rx_sr;
    assign rx_done = rx_done_q;

    // controller waits for the frame to finish before the next one
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rstN) start |-> !tx_busy
    ) else $error("start while a frame is still shifting");

endmodule

// ==== hdl/sbus_master_ctrl.sv ====
// Serial bus master controller.
// Takes one Wishbone classic access at a time, builds the frame header,
// starts the shifter and waits for the addressed slave. Answers with
// ack on completion, or err for slave ID 0 and on watchdog expiry.
`timescale 1ns/1ps

module sbus_master_ctrl (
    input  logic                       clk,
    input  logic                       rstN,
    input  sbus_wb_pkg::wb_req_t       wb_req,
    output sbus_wb_pkg::wb_rsp_t       wb_rsp,
    output sbus_link_pkg::sbus_hdr_u   load_hdr,
    output sbus_wb_pkg::wb_data_t      load_data,
    output logic                       is_write,
    output logic                       start,
    input  logic                       tx_done,
    input  sbus_wb_pkg::wb_data_t      rx_word,
    input  logic                       rx_done,
    input  sbus_link_pkg::sbus_resp_t  slave_rsp [sbus_link_pkg::SLAVES],
    output logic                       merged_rd,
    output logic                       merged_rd_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT_RESP,
        ST_RESPOND
    } ctrl_state_t;

    ctrl_state_t state;

    logic [sbus_link_pkg::SID_W-1:0]     req_sid;
    logic [sbus_link_pkg::LOC_ADR_W-1:0] req_word;
    logic                                accept;
    logic                                merged_ready;
    logic                                start_q;
    logic                                fail_q;
    logic                                seen_busy;
    logic                                ack_q;
    logic                                err_q;
    logic [sbus_link_pkg::WD_W-1:0]      wd_cnt;
    sbus_wb_pkg::wb_data_t               rd_data_q;

    // host address split
    assign req_sid  = wb_req.adr[sbus_wb_pkg::HOST_ADR_W-1:sbus_wb_pkg::HOST_SID_LSB];
    assign req_word = wb_req.adr[sbus_wb_pkg::HOST_SID_LSB-1:0];

    // response pulse must drop before the next request is taken
    assign accept = wb_req.cyc && wb_req.stb && !ack_q && !err_q;

    always_comb begin
        load_hdr.f.start = sbus_link_pkg::START_PAT;
        load_hdr.f.sid   = req_sid;
        load_hdr.f.wr    = wb_req.we;
        load_hdr.f.addr  = req_word;
    end

    assign load_data = wb_req.dat;
    assign is_write  = wb_req.we;
    assign start     = start_q;

    // idle slaves sit at rd low, ready high
    always_comb begin
        merged_rd       = 1'b0;
        merged_rd_valid = 1'b0;
        merged_ready    = 1'b1;
        for (int i = 0; i < sbus_link_pkg::SLAVES; i++) begin
            merged_rd       = merged_rd | slave_rsp[i].rd;
            merged_rd_valid = merged_rd_valid | slave_rsp[i].rd_valid;
            merged_ready    = merged_ready & slave_rsp[i].ready;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= ST_IDLE;
            start_q   <= 1'b0;
            fail_q    <= 1'b0;
            seen_busy <= 1'b0;
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            wd_cnt    <= '0;
        end else begin
            start_q <= 1'b0;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    wd_cnt    <= '0;
                    seen_busy <= 1'b0;
                    if (accept) begin
                        if (req_sid == '0) begin
                            // no slave behind ID 0, no frame goes out
                            fail_q <= 1'b1;
                            state  <= ST_RESPOND;
                        end else begin
                            fail_q  <= 1'b0;
                            start_q <= 1'b1;
                            state   <= ST_SEND;
                        end
                    end
                end
                ST_SEND: begin
                    if (!merged_ready) begin
                        seen_busy <= 1'b1;
                    end
                    if (tx_done) begin
                        state <= ST_WAIT_RESP;
                    end
                end
                ST_WAIT_RESP: begin
                    wd_cnt <= wd_cnt + 1'b1;
                    if (!merged_ready) begin
                        seen_busy <= 1'b1;
                    end
                    if (wb_req.we && seen_busy && merged_ready) begin
                        state <= ST_RESPOND;
                    end else if (!wb_req.we && rx_done) begin
                        state <= ST_RESPOND;
                    end else if (wd_cnt ==
                                 sbus_link_pkg::WD_W'(sbus_link_pkg::RESP_TIMEOUT - 1)) begin
                        // slave never answered
                        fail_q <= 1'b1;
                        state  <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    ack_q <= !fail_q;
                    err_q <= fail_q;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read word held for the ack cycle
    always_ff @(posedge clk) begin
        if (rx_done) begin
            rd_data_q <= rx_word;
        end
    end

    assign wb_rsp = '{ack: ack_q, err: err_q, dat: rd_data_q};

    // a new frame only goes out once every slave has released the link
    a_start_link_idle: assert property (
        @(posedge clk) disable iff (!rstN) start |-> merged_ready
    ) else $error("frame started while a slave still holds the link");

endmodule

// ==== hdl/sbus_link_pkg.sv ====
// Serial link definitions for the memory bus.
// Link sizes, the frame header and the per-direction line bundles
// shared by the master side and the slaves.
package sbus_link_pkg;

    localparam int SLAVES = 3;
    localparam int SID_W = 2;
    localparam int LOC_ADR_W = 8;
    localparam int START_W = 3;
    localparam logic [START_W-1:0] START_PAT = '1;
    localparam int HDR_W = START_W + SID_W + 1 + LOC_ADR_W;

    // header followed by one write word
    localparam int FRAME_W = HDR_W + sbus_wb_pkg::DATA_W;
    localparam int BIT_CNT_W = $clog2(FRAME_W);

    // master watchdog while a slave owns the link
    localparam int RESP_TIMEOUT = 128;
    localparam int WD_W = $clog2(RESP_TIMEOUT);

    // header fields, start pattern goes out first
    typedef struct packed {
        logic [START_W-1:0]   start;
        logic [SID_W-1:0]     sid;
        logic                 wr;
        logic [LOC_ADR_W-1:0] addr;
    } sbus_hdr_fields_t;

    // flat view for shifting, field view for decoding
    typedef union packed {
        logic [HDR_W-1:0] flat;
        sbus_hdr_fields_t f;
    } sbus_hdr_u;

    // master to all slaves
    typedef struct packed {
        logic control;
        logic wd;
        logic valid;
    } sbus_drive_t;

    // one slave back to the master
    typedef struct packed {
        logic rd;
        logic rd_valid;
        logic ready;
    } sbus_resp_t;

endpackage

// ==== hdl/sbus_wb_pkg.sv ====
// Host-side definitions for the serial memory bus.
// Wishbone classic request and response bundles, and the host
// word-address split into slave ID and local word address.
package sbus_wb_pkg;

    localparam int DATA_W = 32;
    localparam int HOST_ADR_W = 10;

    // slave ID in the upper address bits, local word below
    localparam int HOST_SID_LSB = 8;

    typedef logic [DATA_W-1:0] wb_data_t;

    // host to bus, held stable until ack or err
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [HOST_ADR_W-1:0] adr;
        wb_data_t              dat;
    } wb_req_t;

    // bus to host
    typedef struct packed {
        logic     ack;
        logic     err;
        wb_data_t dat;
    } wb_rsp_t;

endpackage
